// File: Bender.yml
package:
  name: md_cart_loader

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/md_cart_pkg.sv
      - rtl/rom_write_bridge.sv
      - rtl/header_region_scan.sv
      - rtl/cart_quirk_match.sv
      - rtl/region_select.sv
      - rtl/cheat_code_loader.sv
      - rtl/md_cart_loader.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/tb_clock_gen.sv
      - sim/md_cart_checker.sv
      - sim/tb_md_cart_loader.sv

// File: md_cart_loader.f
+incdir+rtl
rtl/md_cart_pkg.sv
rtl/rom_write_bridge.sv
rtl/header_region_scan.sv
rtl/cart_quirk_match.sv
rtl/region_select.sv
rtl/cheat_code_loader.sv
rtl/md_cart_loader.sv
sim/tb_clock_gen.sv
sim/md_cart_checker.sv
sim/tb_md_cart_loader.sv

// File: rtl/cart_quirk_match.sv
// Builds the 8-character serial number from the header and looks it up
// The lookup fires once per download, on the word after the serial
`timescale 1ns/100ps
`default_nettype none

`include "md_cart_defines.svh"

module cart_quirk_match import md_cart_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  logic                   cart_active,
	input  logic                   load_wr,
	input  load_addr_t             load_addr,
	input  load_word_t             load_data,
	output logic [`MD_QUIRK_N-1:0] quirks
);

	logic        active_q;
	logic        id_wr;
	logic [63:0] cart_id; // ASCII, first character in the top byte

	// Known titles that need special handling
	function automatic logic [`MD_QUIRK_N-1:0] quirk_lookup(input logic [63:0] id);
		logic [`MD_QUIRK_N-1:0] q;
		q = '0;
		case (id)
			"T-081276", "T-81406 ", "T-081586",
			"T-81576 ", "T-81476 ":               q[SRAM]   = 1'b1;
			"MK-1215 ", "G-4060  ", "00001211",
			"MK-1228 ", "G-5538  ", "00004076",
			"T-12046 ", "T-12053 ", "G-4524  ":   q[EEPROM] = 1'b1;
			"T-113016":                           q[NORAM]  = 1'b1; // Fake RAM check
			"T-89016 ":                           q[FIFO]   = 1'b1;
			"T-574023", "T-574013":               q[PIER]   = 1'b1;
			"MK-1229 ", "G-7001  ":               q[SVP]    = 1'b1; // DSP carts
			"T-35036 ", "T-25073 ", "MK-1137-":   q[FMBUSY] = 1'b1;
			default: ;
		endcase
		return q;
	endfunction

	assign id_wr = cart_active & load_wr;

	// Serial fragments, middle words arrive byte swapped
	always_ff @(posedge clk_sys) begin
		if (id_wr) begin
			case (load_addr)
				`MD_ID_ADDR_0: cart_id[63:56] <= load_data[15:8];
				`MD_ID_ADDR_1: cart_id[55:40] <= {load_data[7:0], load_data[15:8]};
				`MD_ID_ADDR_2: cart_id[39:24] <= {load_data[7:0], load_data[15:8]};
				`MD_ID_ADDR_3: cart_id[23:8]  <= {load_data[7:0], load_data[15:8]};
				`MD_ID_ADDR_4: cart_id[7:0]   <= load_data[7:0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			active_q <= 1'b0;
			quirks   <= '0;
		end else begin
			active_q <= cart_active;
			if (cart_active && !active_q)
				quirks <= '0; // New cartridge
			else if (id_wr && load_addr == `MD_ID_MATCH)
				quirks <= quirks | quirk_lookup(cart_id);
		end
	end

endmodule

`default_nettype wire

// File: rtl/cheat_code_loader.sv
// Packs eight 16-bit words of a cheat file into one 128-bit code
// Layout {flags, address, compare, replace}, each field low word first
`timescale 1ns/100ps
`default_nettype none

`include "md_cart_defines.svh"

module cheat_code_loader import md_cart_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  logic                   code_active,
	input  logic                   load_wr,
	input  load_addr_t             load_addr,
	input  load_word_t             load_data,
	output logic [`MD_CHEAT_W-1:0] cheat_code,
	output logic                   cheat_load,
	output logic                   cheat_clear
);

	logic code_wr;

	assign code_wr     = code_active & load_wr;
	assign cheat_clear = code_wr & (load_addr == '0); // Start of a new cheat list

	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (load_addr[3:0])
				4'd0:  cheat_code[111:96]  <= load_data; // Flags
				4'd2:  cheat_code[127:112] <= load_data;
				4'd4:  cheat_code[79:64]   <= load_data; // Address
				4'd6:  cheat_code[95:80]   <= load_data;
				4'd8:  cheat_code[47:32]   <= load_data; // Compare
				4'd10: cheat_code[63:48]   <= load_data;
				4'd12: cheat_code[15:0]    <= load_data; // Replace
				4'd14: cheat_code[31:16]   <= load_data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			cheat_load <= 1'b0;
		else
			cheat_load <= code_wr && load_addr[3:0] == 4'd14; // Last word in
	end

endmodule

`default_nettype wire

// File: rtl/header_region_scan.sv
// Looks at the region letters of the cartridge header during a cart download
// Flags are sticky until the next download starts
`timescale 1ns/100ps
`default_nettype none

`include "md_cart_defines.svh"

module header_region_scan import md_cart_pkg::*; (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic       cart_active,
	input  logic       load_wr,
	input  load_addr_t load_addr,
	input  load_word_t load_data,
	output logic       hdr_j,
	output logic       hdr_u,
	output logic       hdr_e,
	output logic       hdr_ready
);

	logic       active_q;
	logic       hdr_wr;
	logic [2:0] flag_lo;
	logic [2:0] flag_hi;
	logic [2:0] flag_new;

	// Letter class as {j, u, e}
	function automatic logic [2:0] classify(input logic [7:0] ch);
		logic [2:0] f;
		f = 3'b000;
		if (ch == "J")
			f = 3'b100;
		else if (ch == "U")
			f = 3'b010;
		else if (ch >= "0" && ch <= "Z")
			f = 3'b001; // Any other code means Europe
		return f;
	endfunction

	assign hdr_wr  = cart_active & load_wr;
	assign flag_lo = classify(load_data[7:0]);
	assign flag_hi = classify(load_data[15:8]);

	assign flag_new = ((load_addr == `MD_HDR_REGION_A || load_addr == `MD_HDR_REGION_B) ?
	                   flag_lo : 3'b000) |
	                  ((load_addr == `MD_HDR_REGION_A) ? flag_hi : 3'b000);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			active_q                <= 1'b0;
			{hdr_j, hdr_u, hdr_e}   <= 3'b000;
			hdr_ready               <= 1'b0;
		end else begin
			active_q <= cart_active;
			if (cart_active && !active_q)
				{hdr_j, hdr_u, hdr_e} <= 3'b000;
			else if (hdr_wr)
				{hdr_j, hdr_u, hdr_e} <= {hdr_j, hdr_u, hdr_e} | flag_new;

			if (active_q && !cart_active)
				hdr_ready <= 1'b0;
			else if (hdr_wr && load_addr == `MD_HDR_END)
				hdr_ready <= 1'b1; // Whole header has passed
		end
	end

endmodule

`default_nettype wire

// File: rtl/md_cart_defines.svh
// Widths, cartridge header offsets and key scan codes for the cart loader
// Header offsets are byte addresses of 16-bit loader words
`ifndef MD_CART_DEFINES_SVH
`define MD_CART_DEFINES_SVH

//////////////////////////////////////////////////
// Loader port
`define MD_LOAD_AW       25
`define MD_WORD_W        16

// Region letters and end of header
`define MD_HDR_REGION_A  25'h1F0
`define MD_HDR_REGION_B  25'h1F2
`define MD_HDR_END       25'h200

// Serial number fragments, match one word later
`define MD_ID_ADDR_0     25'h182
`define MD_ID_ADDR_1     25'h184
`define MD_ID_ADDR_2     25'h186
`define MD_ID_ADDR_3     25'h188
`define MD_ID_ADDR_4     25'h18A
`define MD_ID_MATCH      25'h18C

`define MD_QUIRK_N       7
`define MD_CHEAT_W       128

`define MD_KEY_F1        9'h005 // JP
`define MD_KEY_F2        9'h006 // US
`define MD_KEY_F3        9'h004 // EU

`endif

// File: rtl/md_cart_loader.sv
// Cartridge download front end; an all-ones load_index marks a cheat file
// ROM memory sits outside and answers the toggle handshake
`timescale 1ns/100ps
`default_nettype none

`include "md_cart_defines.svh"

module md_cart_loader import md_cart_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  logic                   load_active,
	input  logic [7:0]             load_index,
	input  logic                   load_wr,
	input  load_addr_t             load_addr,
	input  load_word_t             load_data,
	input  logic                   rom_wr_ack,
	input  logic                   key_event,
	input  logic                   key_pressed,
	input  logic [8:0]             key_code,
	input  region_mode_e           region_mode,
	input  region_prio_e           region_prio,
	output logic                   load_wait,
	output load_addr_t             rom_wr_addr,
	output load_word_t             rom_wr_data,
	output logic                   rom_wr_req,
	output load_addr_t             rom_size,
	output region_e                region_req,
	output logic                   region_set,
	output logic [`MD_QUIRK_N-1:0] quirks,
	output logic [`MD_CHEAT_W-1:0] cheat_code,
	output logic                   cheat_load,
	output logic                   cheat_clear
);

	logic code_index;
	logic cart_active;
	logic code_active;
	logic hdr_j, hdr_u, hdr_e, hdr_ready;

	assign code_index  = &load_index;
	assign cart_active = load_active & ~code_index;
	assign code_active = load_active & code_index;

	//////////////////////////////////////////////////
	// Cart path
	rom_write_bridge u_rom_write_bridge (
		.clk_sys, .arst_n, .cart_active, .load_wr, .load_addr, .load_data,
		.rom_wr_ack, .load_wait, .rom_wr_addr, .rom_wr_data, .rom_wr_req, .rom_size
	);

	header_region_scan u_header_region_scan (
		.clk_sys, .arst_n, .cart_active, .load_wr, .load_addr, .load_data,
		.hdr_j, .hdr_u, .hdr_e, .hdr_ready
	);

	cart_quirk_match u_cart_quirk_match (
		.clk_sys, .arst_n, .cart_active, .load_wr, .load_addr, .load_data, .quirks
	);

	region_select u_region_select (
		.clk_sys, .arst_n, .key_event, .key_pressed, .key_code,
		.hdr_j, .hdr_u, .hdr_e, .hdr_ready, .region_mode, .region_prio, .load_index,
		.region_req, .region_set
	);

	//////////////////////////////////////////////////
	// Cheat path
	cheat_code_loader u_cheat_code_loader (
		.clk_sys, .arst_n, .code_active, .load_wr, .load_addr, .load_data,
		.cheat_code, .cheat_load, .cheat_clear
	);

endmodule

`default_nettype wire

// File: rtl/md_cart_pkg.sv
// Types shared by the cartridge download front end
// Enum encodings follow the menu status bits of the console core
`default_nettype none

`include "md_cart_defines.svh"

package md_cart_pkg;

	// Console region, as written back to the menu
	typedef enum logic [1:0] {
		JP = 2'd0,
		US = 2'd1,
		EU = 2'd2
	} region_e;

	// User priority when the header names several regions
	typedef enum logic [1:0] {
		PRIO_US_EU_JP = 2'd0,
		PRIO_EU_US_JP = 2'd1,
		PRIO_US_JP_EU = 2'd2,
		PRIO_JP_US_EU = 2'd3
	} region_prio_e;

	typedef enum logic [1:0] {
		BY_FILE_EXT = 2'd0,
		BY_HEADER   = 2'd1,
		DISABLED    = 2'd2
	} region_mode_e;

	// Value is the bit position in the quirk vector
	typedef enum logic [2:0] {
		SRAM   = 3'd0,
		EEPROM = 3'd1,
		NORAM  = 3'd2,
		FIFO   = 3'd3,
		PIER   = 3'd4,
		SVP    = 3'd5,
		FMBUSY = 3'd6
	} quirk_e;

	typedef logic [`MD_LOAD_AW-1:0] load_addr_t;
	typedef logic [`MD_WORD_W-1:0]  load_word_t;

endpackage

`default_nettype wire

// File: rtl/region_select.sv
// Region request for the menu, from F1..F3, the cartridge header or the file index
// key_event toggles once per key change; code and pressed must be stable with it
`timescale 1ns/100ps
`default_nettype none

`include "md_cart_defines.svh"

module region_select import md_cart_pkg::*; (
	input  logic         clk_sys,
	input  logic         arst_n,
	input  logic         key_event,
	input  logic         key_pressed,
	input  logic [8:0]   key_code,
	input  logic         hdr_j,
	input  logic         hdr_u,
	input  logic         hdr_e,
	input  logic         hdr_ready,
	input  region_mode_e region_mode,
	input  region_prio_e region_prio,
	input  logic [7:0]   load_index,
	output region_e      region_req,
	output logic         region_set
);

	logic       key_sync;
	logic       key_q;
	logic       pressed_q;
	logic [8:0] code_q;
	logic       rdy_d1;
	logic       rdy_d2;

	// First flagged region in priority order, else the head of the order
	function automatic region_e pick_region(input region_prio_e prio,
	                                        input logic j, input logic u, input logic e);
		region_e    ord [3];
		logic [2:0] flag;
		region_e    pick;
		flag = {e, u, j}; // Bit index is the region code
		case (prio)
			PRIO_US_EU_JP: ord = '{US, EU, JP};
			PRIO_EU_US_JP: ord = '{EU, US, JP};
			PRIO_US_JP_EU: ord = '{US, JP, EU};
			default:       ord = '{JP, US, EU};
		endcase
		pick = ord[0];
		for (int i = 2; i >= 0; i--)
			if (flag[ord[i]]) pick = ord[i];
		return pick;
	endfunction

	//////////////////////////////////////////////////
	// Event stages with two cycles from event to request
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			key_sync   <= 1'b0;
			key_q      <= 1'b0;
			pressed_q  <= 1'b0;
			code_q     <= '0;
			rdy_d1     <= 1'b0;
			rdy_d2     <= 1'b0;
			region_req <= JP;
			region_set <= 1'b0;
		end else begin
			key_sync  <= key_event;
			key_q     <= key_sync;
			pressed_q <= key_pressed;
			code_q    <= key_code;
			rdy_d1    <= hdr_ready;
			rdy_d2    <= rdy_d1;

			if (key_sync != key_q) begin
				case (code_q)
					`MD_KEY_F1: begin
						region_req <= JP;
						region_set <= pressed_q;
					end
					`MD_KEY_F2: begin
						region_req <= US;
						region_set <= pressed_q;
					end
					`MD_KEY_F3: begin
						region_req <= EU;
						region_set <= pressed_q;
					end
					default: ;
				endcase
			end

			if (rdy_d1 && !rdy_d2 && region_mode != DISABLED) begin
				if (region_mode == BY_HEADER) begin
					region_req <= pick_region(region_prio, hdr_j, hdr_u, hdr_e);
					region_set <= 1'b1;
				end else begin
					region_req <= region_e'(load_index[7:6]); // Index carries the region
					region_set <= |load_index;
				end
			end

			if (rdy_d2 && !rdy_d1)
				region_set <= 1'b0; // Download finished
		end
	end

endmodule

`default_nettype wire

// File: rtl/rom_write_bridge.sv
// One ROM write in flight at a time; the loader must not strobe while load_wait is high
// Memory completes a write by making rom_wr_ack equal to rom_wr_req
`timescale 1ns/100ps
`default_nettype none

module rom_write_bridge import md_cart_pkg::*; (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic       cart_active,
	input  logic       load_wr,
	input  load_addr_t load_addr,
	input  load_word_t load_data,
	input  logic       rom_wr_ack,
	output logic       load_wait,
	output load_addr_t rom_wr_addr,
	output load_word_t rom_wr_data,
	output logic       rom_wr_req,
	output load_addr_t rom_size
);

	logic       active_q;
	logic       dl_start;
	logic       dl_end;
	load_addr_t wr_addr_q;
	load_word_t wr_data_q;

	assign dl_start = cart_active & ~active_q;
	assign dl_end   = active_q & ~cart_active;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			active_q   <= 1'b0;
			rom_wr_req <= 1'b0;
			load_wait  <= 1'b0;
			rom_size   <= '0;
		end else begin
			active_q <= cart_active;
			if (dl_end) begin
				rom_size  <= load_addr; // Last address of the image
				load_wait <= 1'b0;
			end
			if (dl_start) begin
				rom_wr_req <= load_wr; // Fresh toggle phase per download
				load_wait  <= load_wr;
			end else if (cart_active) begin
				if (load_wr) begin
					rom_wr_req <= ~rom_wr_req;
					load_wait  <= 1'b1;
				end else if (load_wait && (rom_wr_req == rom_wr_ack)) begin
					load_wait <= 1'b0; // Memory caught up
				end
			end
		end
	end

	// Word held for the memory until it acknowledges
	always_ff @(posedge clk_sys) begin
		if (cart_active && load_wr) begin
			wr_addr_q <= load_addr;
			wr_data_q <= {load_data[7:0], load_data[15:8]}; // Byte swap
		end
	end

	assign rom_wr_addr = cart_active ? wr_addr_q : rom_size;
	assign rom_wr_data = wr_data_q;

endmodule

`default_nettype wire

// File: sim/md_cart_checker.sv
// Handshake rules of the cart loader, bound into md_cart_loader
// Rules are sampled on clk_sys and are off while arst_n is low
`timescale 1ns/100ps
`default_nettype none

module md_cart_checker (
	input logic clk_sys,
	input logic arst_n,
	input logic cart_active,
	input logic load_wr,
	input logic load_wait,
	input logic rom_wr_req,
	input logic cheat_load
);

	int fail_count = 0;

	// No write can be pending right out of reset
	wait_after_reset: assert property (@(posedge clk_sys) $rose(arst_n) |-> !load_wait)
		else begin
			$error("load_wait high in the cycle after reset");
			fail_count++;
		end

	cheat_load_single: assert property (@(posedge clk_sys) disable iff (!arst_n)
		cheat_load |=> !cheat_load)
		else begin
			$error("cheat_load held for two cycles");
			fail_count++;
		end

	// Toggle only after a cart strobe, or the clear at download start
	req_toggle_cause: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$changed(rom_wr_req) |->
			$past(cart_active && load_wr) || ($past(cart_active) && !$past(cart_active, 2)))
		else begin
			$error("rom_wr_req changed without a cart write strobe");
			fail_count++;
		end

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
// Free-running 8 ns clock, reset held low for the first 16 cycles
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
	output logic clk_sys,
	output logic arst_n
);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	initial begin
		arst_n = 1'b0;
		repeat (16) @(posedge clk_sys);
		@(negedge clk_sys);
		arst_n = 1'b1; // Release away from the active edge
	end

endmodule

`default_nettype wire

// File: sim/tb_md_cart_loader.sv
// Directed tests of the cart download front end with a toggle-handshake ROM model
// Memory answers each request after 1..6 cycles; stimulus moves on the falling edge
`timescale 1ns/100ps
`default_nettype none

`include "md_cart_defines.svh"

module tb_md_cart_loader import md_cart_pkg::*; ();

	// Writes and downloads in all tests set the run limit
	localparam int N_WRITES    = 149;
	localparam int WRITE_CYC   = 10; // Strobe, 6 cycle ack, load_wait release, margin
	localparam int N_DOWNLOADS = 39;
	localparam int DL_CYC      = 16;
	localparam int TIMEOUT_CYC = 16 + N_WRITES * WRITE_CYC + N_DOWNLOADS * DL_CYC + 200;

	logic                   clk_sys, arst_n;
	logic                   load_active, load_wr;
	logic [7:0]             load_index;
	load_addr_t             load_addr;
	load_word_t             load_data;
	logic                   rom_wr_ack = 1'b0;
	logic                   key_event, key_pressed;
	logic [8:0]             key_code;
	region_mode_e           region_mode;
	region_prio_e           region_prio;
	logic                   load_wait, rom_wr_req;
	load_addr_t             rom_wr_addr, rom_size;
	load_word_t             rom_wr_data;
	region_e                region_req;
	logic                   region_set;
	logic [`MD_QUIRK_N-1:0] quirks;
	logic [`MD_CHEAT_W-1:0] cheat_code, cheat_seen;
	logic                   cheat_load, cheat_clear;

	logic [31:0] lfsr = 32'he65ee601;
	logic        mem_busy = 1'b0;
	int          mem_delay = 0;
	load_addr_t  mem_addr_q [$];
	load_word_t  mem_data_q [$];
	int          cheat_loads = 0;
	int          value_errs = 0;
	int          other_errs = 0;
	int          cycles = 0;

	tb_clock_gen u_clock_gen (.clk_sys, .arst_n);

	md_cart_loader DUT (.*);

	bind md_cart_loader md_cart_checker u_checker (
		.clk_sys, .arst_n, .cart_active, .load_wr, .load_wait, .rom_wr_req, .cheat_load
	);

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	//////////////////////////////////////////////////
	// ROM model that logs each acknowledged write
	always @(negedge clk_sys) begin
		if (!load_active) begin
			rom_wr_ack <= 1'b0; // Toggle phase restarts with each download
			mem_busy   <= 1'b0;
		end else if (mem_busy) begin
			if (mem_delay == 1) begin
				rom_wr_ack <= rom_wr_req;
				mem_busy   <= 1'b0;
				mem_addr_q.push_back(rom_wr_addr);
				mem_data_q.push_back(rom_wr_data);
			end
			mem_delay <= mem_delay - 1;
		end else if (load_wait && rom_wr_req != rom_wr_ack) begin
			mem_busy  <= 1'b1;
			mem_delay <= 1 + rand_bits(3) % 6;
		end
	end

	always @(negedge clk_sys) begin
		if (cheat_load) begin
			cheat_loads++;
			cheat_seen = cheat_code;
		end
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYC) begin
			$display("Timeout: run exceeded %0d cycles", TIMEOUT_CYC);
			$display("Test failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Compare tasks
	task automatic check_region(input string name, input region_e got, input region_e exp);
		if (got !== exp) begin
			value_errs++;
			$display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input load_word_t got, input load_word_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input load_addr_t got, input load_addr_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic check_bits(input string name, input logic [`MD_CHEAT_W-1:0] got,
	                          input logic [`MD_CHEAT_W-1:0] exp);
		if (got !== exp) begin
			value_errs++;
			$display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		other_errs++;
		$display("Failure at %0t ns: %s", $time, what);
	endtask

	// First flagged region of the priority order, else the head of the order
	function automatic region_e expect_region(input region_prio_e prio, input logic [2:0] jue);
		logic [5:0] order; // Highest priority in the top bits
		region_e    r;
		case (prio)
			PRIO_US_EU_JP: order = {US, EU, JP};
			PRIO_EU_US_JP: order = {EU, US, JP};
			PRIO_US_JP_EU: order = {US, JP, EU};
			default:       order = {JP, US, EU};
		endcase
		for (int i = 0; i < 3; i++) begin
			r = region_e'(order[5 - 2 * i -: 2]);
			if (jue[2 - r])
				return r;
		end
		return region_e'(order[5:4]);
	endfunction

	//////////////////////////////////////////////////
	// Loader sequences
	task automatic start_download(input logic [7:0] index);
		@(negedge clk_sys);
		load_index  = index;
		load_active = 1'b1;
		@(negedge clk_sys);
	endtask

	// hdr_ready drops one cycle later, region_set two after that
	task automatic end_download();
		@(negedge clk_sys);
		load_active = 1'b0;
		repeat (4) @(negedge clk_sys);
	endtask

	task automatic cart_write(input load_addr_t addr, input load_word_t data);
		int n;
		n = mem_addr_q.size();
		@(negedge clk_sys);
		load_addr = addr;
		load_data = data;
		load_wr   = 1'b1;
		@(negedge clk_sys);
		load_wr = 1'b0;
		if (!load_wait)
			report_failure("load_wait did not rise after a cart write");
		while (load_wait)
			@(negedge clk_sys);
		if (rom_wr_req !== rom_wr_ack)
			report_failure("load_wait fell before the memory acknowledged");
		if (mem_addr_q.size() != n + 1) begin
			report_failure("cart write did not give exactly one ROM request");
		end else begin
			check_addr("rom_wr_addr", mem_addr_q[n], addr);
			check_word("rom_wr_data", mem_data_q[n], {data[7:0], data[15:8]});
		end
	endtask

	task automatic code_write(input load_addr_t addr, input load_word_t data);
		@(negedge clk_sys);
		load_addr = addr;
		load_data = data;
		load_wr   = 1'b1;
		@(posedge clk_sys);
		check_bits("cheat_clear", cheat_clear, addr == '0);
		@(negedge clk_sys);
		load_wr = 1'b0;
	endtask

	// Request follows the key change by two cycles
	task automatic key_change(input logic [8:0] code, input logic pressed);
		@(negedge clk_sys);
		key_code    = code;
		key_pressed = pressed;
		key_event   = ~key_event;
		repeat (3) @(negedge clk_sys);
	endtask

	//////////////////////////////////////////////////
	// Tests
	task automatic test_rom_writes();
		load_addr_t a;
		region_mode = DISABLED;
		start_download(8'h01);
		for (int i = 0; i < 16; i++) begin
			a = 25'h400 + 2 * i;
			cart_write(a, load_word_t'(rand_bits(16)));
		end
		end_download();
		check_addr("rom_size", rom_size, a);
		check_addr("rom_wr_addr", rom_wr_addr, a);
	endtask

	task automatic test_header_region();
		load_word_t wa [6] = '{{"J", " "}, {"U", " "}, {" ", "E"}, {"J", "U"}, {" ", " "},
		                       {" ", "U"}};
		load_word_t wb [6] = '{{" ", " "}, {" ", "J"}, {" ", " "}, {" ", "4"}, {"J", " "},
		                       {" ", "B"}};
		logic [2:0] fl [6] = '{3'b100, 3'b110, 3'b001, 3'b111, 3'b000, 3'b011}; // {j, u, e}
		region_mode = BY_HEADER;
		for (int p = 0; p < 4; p++) begin
			for (int c = 0; c < 6; c++) begin
				region_prio = region_prio_e'(p);
				start_download(8'h01);
				cart_write(`MD_HDR_REGION_A, wa[c]);
				cart_write(`MD_HDR_REGION_B, wb[c]);
				cart_write(`MD_HDR_END, 16'h0000);
				repeat (2) @(negedge clk_sys);
				check_region("region_req", region_req, expect_region(region_prio, fl[c]));
				check_bits("region_set", region_set, 1);
				end_download();
				check_bits("region_set", region_set, 0);
			end
		end
	endtask

	task automatic test_index_and_keys();
		logic [7:0] idx [5] = '{8'h01, 8'h41, 8'h00, 8'hC0 & 8'h80, 8'h81};
		region_e    exp_r [5] = '{JP, US, JP, EU, EU};
		logic       exp_s [5] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b1};
		region_mode = BY_FILE_EXT;
		for (int i = 0; i < 5; i++) begin
			start_download(idx[i]);
			cart_write(`MD_HDR_END, 16'h0000);
			repeat (2) @(negedge clk_sys);
			check_region("region_req", region_req, exp_r[i]);
			check_bits("region_set", region_set, exp_s[i]);
			if (i < 4)
				end_download();
		end
		key_change(`MD_KEY_F2, 1'b1); // Overrides the index while loading
		check_region("region_req", region_req, US);
		check_bits("region_set", region_set, 1);
		key_change(`MD_KEY_F2, 1'b0);
		check_region("region_req", region_req, US);
		check_bits("region_set", region_set, 0);
		end_download();
		key_change(`MD_KEY_F1, 1'b1);
		check_region("region_req", region_req, JP);
		check_bits("region_set", region_set, 1);
		key_change(`MD_KEY_F3, 1'b1);
		key_change(9'h01C, 1'b1); // Not a region key
		check_region("region_req", region_req, EU);
		check_bits("region_set", region_set, 1);
		key_change(`MD_KEY_F3, 1'b0);
		check_bits("region_set", region_set, 0);
	endtask

	task automatic test_quirks();
		logic [63:0] ids [8] = '{"T-081276", "MK-1215 ", "T-113016", "T-89016 ", "T-574023",
		                         "MK-1229 ", "T-35036 ", "T-99999 "};
		quirk_e      cls [7] = '{SRAM, EEPROM, NORAM, FIFO, PIER, SVP, FMBUSY};
		logic [`MD_QUIRK_N-1:0] exp_q;
		logic [63:0] id;
		region_mode = DISABLED;
		for (int i = 0; i < 8; i++) begin
			id = ids[i];
			start_download(8'h02);
			check_bits("quirks", quirks, 0); // Previous cartridge forgotten
			cart_write(`MD_ID_ADDR_0, {id[63:56], 8'h00});
			cart_write(`MD_ID_ADDR_1, {id[47:40], id[55:48]});
			cart_write(`MD_ID_ADDR_2, {id[31:24], id[39:32]});
			cart_write(`MD_ID_ADDR_3, {id[15:8], id[23:16]});
			cart_write(`MD_ID_ADDR_4, {8'h00, id[7:0]});
			cart_write(`MD_ID_MATCH, 16'h0000);
			exp_q = '0;
			if (i < 7)
				exp_q[cls[i]] = 1'b1;
			check_bits("quirks", quirks, exp_q);
			end_download();
		end
	endtask

	task automatic test_cheats();
		load_word_t w [8];
		int         loads;
		int         reqs;
		for (int i = 0; i < 8; i++)
			w[i] = load_word_t'(rand_bits(16));
		loads = cheat_loads;
		reqs  = mem_addr_q.size();
		start_download(8'hFF);
		for (int i = 0; i < 8; i++) begin
			code_write(load_addr_t'(2 * i), w[i]);
			check_bits("load_wait", load_wait, 0); // Cheat words never stall the loader
		end
		end_download();
		if (cheat_loads != loads + 1)
			report_failure("cheat file did not give exactly one cheat_load");
		check_bits("cheat_code", cheat_seen,
		           {w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]});
		if (mem_addr_q.size() != reqs)
			report_failure("cheat download reached the ROM memory");
	endtask

	initial begin
		load_active = 1'b0;
		load_index  = 8'h00;
		load_wr     = 1'b0;
		load_addr   = '0;
		load_data   = '0;
		key_event   = 1'b0;
		key_pressed = 1'b0;
		key_code    = '0;
		region_mode = DISABLED;
		region_prio = PRIO_US_EU_JP;
		wait (arst_n === 1'b1);
		@(negedge clk_sys);
		check_bits("load_wait", load_wait, 0);
		check_bits("rom_wr_req", rom_wr_req, 0);
		check_bits("region_set", region_set, 0);
		check_bits("cheat_load", cheat_load, 0);
		check_bits("hdr_ready", DUT.hdr_ready, 0);
		check_bits("quirks", quirks, 0);
		test_rom_writes();
		test_header_region();
		test_index_and_keys();
		test_quirks();
		test_cheats();
		$display("Errors: %0d value, %0d other, %0d assertion", value_errs, other_errs,
		         DUT.u_checker.fail_count);
		if (value_errs + other_errs + DUT.u_checker.fail_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire
